// File: src/fpu_fmt_pkg.sv
/* single-precision field widths, exponent bias, conversion exponent limits
   and the rounding-mode enum */

package fpu_fmt_pkg;

  // ==========================================================
  // ieee 754 single precision
  // ==========================================================
  localparam int unsigned exp_width = 8;
  localparam int unsigned man_width = 23;
  localparam logic [exp_width-1:0] exp_bias = 8'd127;

  // float-to-int exponent window
  localparam logic [exp_width-1:0] f2i_max_exp = 8'd157;  // 2^30, still fits in 32 bits
  localparam logic [exp_width-1:0] f2i_min_exp = 8'd125;  // 0.25, smallest that rounds

  // codes 5..7 are reserved, treated as toward-zero
  typedef enum logic [2:0] {
    RNE = 3'd0,  // nearest, ties to even
    RTZ = 3'd1,  // toward zero
    RDN = 3'd2,  // toward -inf
    RUP = 3'd3,  // toward +inf
    RMM = 3'd4   // nearest, ties away
  } rm_e;

endpackage

// File: src/fpu_cvt_pkg.sv
/* transaction definitions for the conversion subsystem:
   opcodes, word and tag widths, unit indices */

package fpu_cvt_pkg;

  // ==========================================================
  // request / result words
  // ==========================================================
  localparam int unsigned word_width = 32;
  localparam int unsigned tag_width  = 4;

  // ==========================================================
  // execution units behind the shared result bus
  // ==========================================================
  localparam int unsigned num_units = 2;
  localparam int unsigned unit_f2i  = 0;
  localparam int unsigned unit_i2f  = 1;

  typedef enum logic [0:0] {
    OP_F2I = 1'b0,  // float to signed int
    OP_I2F = 1'b1   // signed int to float
  } op_e;

endpackage

// File: src/fpu_res_if.sv
/* result bus between one conversion unit and the result arbiter */

`timescale 1ns/10ps

interface fpu_res_if;

  logic                                valid;
  logic                                ready;
  logic [fpu_cvt_pkg::word_width-1:0]  data;
  logic [fpu_cvt_pkg::tag_width-1:0]   tag;

  // unit side, holds a result until ready
  modport unit (
    output valid,
    output data,
    output tag,
    input  ready
  );

  // arbiter side
  modport arbiter (
    input  valid,
    input  data,
    input  tag,
    output ready
  );

endinterface

// File: src/fpu_classify.sv
/* single-precision operand split into sign, exponent and mantissa,
   with zero, infinity and NaN detection */

`timescale 1ns/10ps

module fpu_classify (
  input  logic [fpu_cvt_pkg::word_width-1:0]  a_i,
  output logic                                zero_o,
  output logic                                infty_o,
  output logic                                nan_o,
  output logic                                sign_o,
  output logic [fpu_fmt_pkg::exp_width-1:0]   exp_o,
  output logic [fpu_fmt_pkg::man_width-1:0]   man_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // ==========================================================
  // field split
  // ==========================================================
  assign sign_o = a_i[fpu_cvt_pkg::word_width-1];
  assign exp_o  = a_i[fpu_fmt_pkg::man_width +: fpu_fmt_pkg::exp_width];
  assign man_o  = a_i[fpu_fmt_pkg::man_width-1:0];

  // ==========================================================
  // classes
  // ==========================================================
  assign exp_zero = (exp_o == '0);
  assign exp_ones = &exp_o;
  assign man_zero = (man_o == '0);

  assign zero_o  = exp_zero;               // denormals flush to zero
  assign infty_o = exp_ones & man_zero;
  assign nan_o   = exp_ones & ~man_zero;   // quiet and signalling alike

endmodule

// File: src/fpu_round.sv
/* round-up decision for a sign-magnitude value from lsb, guard, round,
   sticky and the rounding mode */

`timescale 1ns/10ps

module fpu_round (
  input  logic               sign_i,
  input  logic               lsb_i,
  input  logic               guard_i,
  input  logic               round_i,
  input  logic               sticky_i,
  input  fpu_fmt_pkg::rm_e   rm_i,
  output logic               do_round_o
);

  logic inexact;

  assign inexact = guard_i | round_i | sticky_i;

  always_comb begin
    case (rm_i)
      fpu_fmt_pkg::RNE: begin
        do_round_o = guard_i & (round_i | sticky_i | lsb_i);  // ties go to even
      end
      fpu_fmt_pkg::RTZ: begin
        do_round_o = 1'b0;
      end
      fpu_fmt_pkg::RDN: begin
        do_round_o = sign_i & inexact;     // magnitude grows when negative
      end
      fpu_fmt_pkg::RUP: begin
        do_round_o = ~sign_i & inexact;
      end
      fpu_fmt_pkg::RMM: begin
        do_round_o = guard_i;
      end
      default: begin
        do_round_o = 1'b0;                 // reserved codes
      end
    endcase
  end

endmodule

// File: src/fpu_f2i.sv
/* float-to-int conversion unit, single precision to signed 32-bit,
   with a one-entry output register on a valid/ready result bus */

`timescale 1ns/10ps

module fpu_f2i (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  input  logic [fpu_cvt_pkg::word_width-1:0]  a_i,
  input  fpu_fmt_pkg::rm_e                    rm_i,
  input  logic [fpu_cvt_pkg::tag_width-1:0]   tag_i,
  fpu_res_if.unit                             res
);

  logic                               sign;
  logic [fpu_fmt_pkg::exp_width-1:0]  exp;
  logic [fpu_fmt_pkg::man_width-1:0]  man;
  logic                               zero;
  logic                               infty;
  logic                               nan;

  fpu_classify u_classify (
    .a_i     (a_i),
    .zero_o  (zero),
    .infty_o (infty),
    .nan_o   (nan),
    .sign_o  (sign),
    .exp_o   (exp),
    .man_o   (man)
  );

  // ==========================================================
  // alignment
  // ==========================================================
  logic       exp_too_big;
  logic       exp_too_small;
  logic [7:0] shamt;
  logic [32:0] preshift;
  logic [32:0] shifted;
  logic [32:0] lost_mask;
  logic       sticky;

  assign exp_too_big   = infty | nan | (exp > fpu_fmt_pkg::f2i_max_exp);
  assign exp_too_small = (exp < fpu_fmt_pkg::f2i_min_exp);

  // tiny values shift everything into sticky
  assign shamt = exp_too_small
    ? fpu_fmt_pkg::f2i_max_exp - (fpu_fmt_pkg::f2i_min_exp - 8'd1)
    : fpu_fmt_pkg::f2i_max_exp - exp;

  assign preshift  = {1'b1, man, 9'b0};  // int bits, then guard and round
  assign shifted   = preshift >> shamt[5:0];
  assign lost_mask = ~({33{1'b1}} << shamt[5:0]);
  assign sticky    = |(preshift & lost_mask);

  // ==========================================================
  // rounding and sign
  // ==========================================================
  logic        do_round;
  logic [31:0] inverted;
  logic [31:0] post_round;
  logic [31:0] res_d;

  fpu_round u_round (
    .sign_i     (sign),
    .lsb_i      (shifted[2]),
    .guard_i    (shifted[1]),
    .round_i    (shifted[0]),
    .sticky_i   (sticky),
    .rm_i       (rm_i),
    .do_round_o (do_round)
  );

  // ones' complement plus carry-in folds negate and round
  assign inverted   = {32{sign}} ^ {1'b0, shifted[32:2]};
  assign post_round = inverted + {31'b0, do_round ^ sign};

  always_comb begin
    if (zero) begin
      res_d = 32'h0000_0000;
    end else if (exp_too_big) begin
      res_d = 32'h8000_0000;
    end else if (exp_too_small) begin
      if (rm_i == fpu_fmt_pkg::RDN) begin
        res_d = do_round ? 32'hffff_ffff : 32'h0000_0000;
      end else if (rm_i == fpu_fmt_pkg::RUP) begin
        res_d = do_round ? 32'h0000_0001 : 32'h0000_0000;
      end else begin
        res_d = 32'h0000_0000;
      end
    end else begin
      res_d = post_round;
    end
  end

  // ==========================================================
  // output register
  // ==========================================================
  logic load;

  assign in_ready_o = ~res.valid | res.ready;  // empty or draining now
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res.valid <= 1'b0;
    end else if (load) begin
      res.valid <= 1'b1;
    end else if (res.ready) begin
      res.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      res.data <= res_d;
      res.tag  <= tag_i;
    end
  end

  // held result stays put under back-pressure
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res.valid && !res.ready |=> res.valid && $stable(res.data) && $stable(res.tag));

endmodule

// File: src/fpu_i2f.sv
/* int-to-float conversion unit, signed 32-bit to single precision,
   with a one-entry output register on a valid/ready result bus */

`timescale 1ns/10ps

module fpu_i2f (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  input  logic [fpu_cvt_pkg::word_width-1:0]  a_i,
  input  fpu_fmt_pkg::rm_e                    rm_i,
  input  logic [fpu_cvt_pkg::tag_width-1:0]   tag_i,
  fpu_res_if.unit                             res
);

  // ==========================================================
  // magnitude and normalisation
  // ==========================================================
  logic        sign;
  logic [31:0] mag;
  logic [4:0]  lead;
  logic [31:0] norm;
  logic [fpu_fmt_pkg::exp_width-1:0] exp;

  assign sign = a_i[31];
  assign mag  = sign ? (~a_i + 32'd1) : a_i;  // 80000000 stays as 2^31

  // leading one, highest set bit wins
  always_comb begin
    lead = 5'd0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) begin
        lead = 5'(i);
      end
    end
  end

  assign norm = mag << (5'd31 - lead);  // hidden bit lands in bit 31
  assign exp  = fpu_fmt_pkg::exp_bias + {3'b0, lead};

  // ==========================================================
  // rounding
  // ==========================================================
  logic        do_round;
  logic [30:0] rounded;
  logic [31:0] res_d;

  fpu_round u_round (
    .sign_i     (sign),
    .lsb_i      (norm[8]),
    .guard_i    (norm[7]),
    .round_i    (norm[6]),
    .sticky_i   (|norm[5:0]),
    .rm_i       (rm_i),
    .do_round_o (do_round)
  );

  // mantissa carry ripples into the exponent field
  assign rounded = {exp, norm[30:8]} + {30'b0, do_round};
  assign res_d   = (mag == 32'd0) ? 32'h0000_0000 : {sign, rounded};

  // ==========================================================
  // output register
  // ==========================================================
  logic load;

  assign in_ready_o = ~res.valid | res.ready;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res.valid <= 1'b0;
    end else if (load) begin
      res.valid <= 1'b1;
    end else if (res.ready) begin
      res.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      res.data <= res_d;
      res.tag  <= tag_i;
    end
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res.valid && !res.ready |=> res.valid && $stable(res.data) && $stable(res.tag));

endmodule

// File: src/fpu_res_arbiter.sv
/* round-robin arbiter placing one unit's result on the shared result bus */

`timescale 1ns/10ps

module fpu_res_arbiter (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  fpu_res_if.arbiter                          unit_f2i,
  fpu_res_if.arbiter                          unit_i2f,
  output logic                                res_valid_o,
  input  logic                                res_ready_i,
  output logic [fpu_cvt_pkg::word_width-1:0]  res_data_o,
  output logic [fpu_cvt_pkg::tag_width-1:0]   res_tag_o
);

  logic [fpu_cvt_pkg::num_units-1:0] valid;
  logic [fpu_cvt_pkg::num_units-1:0] gnt;
  logic ptr;       // favoured unit on a tie
  logic sel;       // granted unit index
  logic xfer;
  logic lock_q;    // result stalled last cycle
  logic lock_sel_q;

  assign valid[fpu_cvt_pkg::unit_f2i] = unit_f2i.valid;
  assign valid[fpu_cvt_pkg::unit_i2f] = unit_i2f.valid;

  // ==========================================================
  // grant
  // ==========================================================
  always_comb begin
    gnt = '0;
    if (lock_q) begin
      gnt[lock_sel_q] = 1'b1;  // stalled result keeps the bus
    end else if (&valid) begin
      gnt[ptr] = 1'b1;
    end else begin
      gnt = valid;
    end
  end

  assign sel = gnt[fpu_cvt_pkg::unit_i2f];

  assign res_valid_o = |valid;
  assign res_data_o  = sel ? unit_i2f.data : unit_f2i.data;
  assign res_tag_o   = sel ? unit_i2f.tag : unit_f2i.tag;

  assign unit_f2i.ready = gnt[fpu_cvt_pkg::unit_f2i] & res_ready_i;
  assign unit_i2f.ready = gnt[fpu_cvt_pkg::unit_i2f] & res_ready_i;

  // ==========================================================
  // round-robin pointer
  // ==========================================================
  assign xfer = res_valid_o & res_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr <= 1'(fpu_cvt_pkg::unit_f2i);
    end else if (xfer) begin
      ptr <= ~sel;   // loser of this round goes first next time
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else begin
      lock_q     <= res_valid_o & ~res_ready_i;
      lock_sel_q <= sel;
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt));

  a_gnt_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (gnt & ~valid) == '0);

endmodule

// File: src/fpu_cvt_top.sv
/* conversion subsystem top, request dispatch to the float-to-int and
   int-to-float units and the shared result arbiter */

`timescale 1ns/10ps

module fpu_cvt_top (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  fpu_cvt_pkg::op_e                    req_op_i,
  input  logic [2:0]                          req_rm_i,
  input  logic [fpu_cvt_pkg::word_width-1:0]  req_data_i,
  input  logic [fpu_cvt_pkg::tag_width-1:0]   req_tag_i,
  // result
  output logic                                res_valid_o,
  input  logic                                res_ready_i,
  output logic [fpu_cvt_pkg::word_width-1:0]  res_data_o,
  output logic [fpu_cvt_pkg::tag_width-1:0]   res_tag_o
);

  fpu_res_if f2i_res ();
  fpu_res_if i2f_res ();

  logic             f2i_valid;
  logic             f2i_ready;
  logic             i2f_valid;
  logic             i2f_ready;
  logic             is_f2i;
  fpu_fmt_pkg::rm_e rm;

  // ==========================================================
  // dispatch
  // ==========================================================
  assign is_f2i      = (req_op_i == fpu_cvt_pkg::OP_F2I);
  assign f2i_valid   = req_valid_i & is_f2i;
  assign i2f_valid   = req_valid_i & ~is_f2i;
  assign req_ready_o = is_f2i ? f2i_ready : i2f_ready;
  assign rm          = fpu_fmt_pkg::rm_e'(req_rm_i);  // 5..7 pass through as reserved

  fpu_f2i u_f2i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_valid_i (f2i_valid),
    .in_ready_o (f2i_ready),
    .a_i        (req_data_i),
    .rm_i       (rm),
    .tag_i      (req_tag_i),
    .res        (f2i_res.unit)
  );

  fpu_i2f u_i2f (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_valid_i (i2f_valid),
    .in_ready_o (i2f_ready),
    .a_i        (req_data_i),
    .rm_i       (rm),
    .tag_i      (req_tag_i),
    .res        (i2f_res.unit)
  );

  fpu_res_arbiter u_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .unit_f2i    (f2i_res.arbiter),
    .unit_i2f    (i2f_res.arbiter),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_data_o  (res_data_o),
    .res_tag_o   (res_tag_o)
  );

endmodule

// File: verification/fpu_cvt_model.svh
/* reference models for float-to-int and int-to-float conversion,
   rounding decision and the Fibonacci LFSR used for random stimulus */

`ifndef fpu_cvt_model_svh
`define fpu_cvt_model_svh

// ==========================================================
// random numbers
// ==========================================================
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
endfunction

function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    state = lfsr_next(state);  // one step per bit
    v = {v[30:0], state[0]};
  end
  return v;
endfunction

// ==========================================================
// conversion models
// ==========================================================
function automatic logic round_up(input logic sign, input logic lsb, input logic guard,
                                  input logic rnd, input logic sticky, input logic [2:0] rm);
  logic any;
  any = guard | rnd | sticky;
  case (rm)
    fpu_fmt_pkg::RNE: return guard & (rnd | sticky | lsb);
    fpu_fmt_pkg::RDN: return sign & any;
    fpu_fmt_pkg::RUP: return !sign & any;
    fpu_fmt_pkg::RMM: return guard;
    default: return 1'b0;  // toward zero and reserved
  endcase
endfunction

function automatic logic [31:0] f2i_ref(input logic [31:0] a, input logic [2:0] rm);
  logic        sign;
  logic [7:0]  e;
  logic [63:0] fx;
  logic [31:0] mag;
  logic        up;
  sign = a[31];
  e    = a[30:23];
  if (e == 8'd0) begin
    return 32'h0000_0000;  // zero and denormals
  end
  if (e > 8'd157) begin
    return 32'h8000_0000;  // includes inf and nan
  end
  if (e < 8'd125) begin
    if (rm == fpu_fmt_pkg::RDN && sign) begin
      return 32'hffff_ffff;
    end
    if (rm == fpu_fmt_pkg::RUP && !sign) begin
      return 32'h0000_0001;
    end
    return 32'h0000_0000;
  end
  fx  = {40'd0, 1'b1, a[22:0]} << (e - 8'd118);  // 32 integer . 32 fraction bits
  up  = round_up(sign, fx[32], fx[31], fx[30], |fx[29:0], rm);
  mag = fx[63:32] + {31'd0, up};
  return sign ? (~mag + 32'd1) : mag;
endfunction

function automatic logic [31:0] i2f_ref(input logic [31:0] a, input logic [2:0] rm);
  logic        sign;
  logic [31:0] mag;
  logic [63:0] fx;
  logic [30:0] body;
  logic        up;
  int          p;
  if (a == 32'h0000_0000) begin
    return 32'h0000_0000;
  end
  sign = a[31];
  mag  = sign ? -a : a;
  p    = 0;
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) begin
      p = i;
    end
  end
  fx   = {mag, 32'd0} >> p;  // hidden bit at 32
  up   = round_up(sign, fx[9], fx[8], fx[7], |fx[6:0], rm);
  body = {8'(127 + p), fx[31:9]} + {30'd0, up};  // carry may bump exponent
  return {sign, body};
endfunction

`endif

// File: verification/tb_fpu_cvt.sv
/* testbench for the conversion subsystem: random stimulus, scoreboard
   against the reference model, fairness and hold checks, watchdog */

`timescale 1ns/10ps

module tb_fpu_cvt;

  localparam int num_tests  = 6;
  localparam int n_f2i_rand = 80;
  localparam int n_f2i_spec = 13 * 8;
  localparam int n_i2f      = 8 * 5 + 60;
  localparam int n_bp       = 80;
  localparam int n_mixed    = 100;
  localparam int wd_cycles  = (n_f2i_rand + n_f2i_spec + n_i2f + n_bp + n_mixed) * 20 + 200;

  localparam logic [31:0] f2i_specials [13] = '{
    32'h0000_0000, 32'h8000_0000, 32'h0001_2345, 32'h8040_0000,  // zeros, denormals
    32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'h4f00_0000,  // inf, nan, 2^31
    32'hcf00_0000, 32'h3e00_0000, 32'hbe00_0000, 32'h3e80_0000,  // tiny, 0.25
    32'hbf40_0000
  };
  localparam logic [31:0] i2f_fixed [8] = '{
    32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
    32'h0100_0001, 32'h0180_0001, 32'hfeff_ffff, 32'h0000_0001
  };

  logic             clk = 1'b0;
  logic             arst_n;
  logic             req_valid;
  logic             req_ready;
  fpu_cvt_pkg::op_e req_op;
  logic [2:0]       req_rm;
  logic [31:0]      req_data;
  logic [3:0]       req_tag;
  logic             res_valid;
  logic             res_ready;
  logic [31:0]      res_data;
  logic [3:0]       res_tag;

  // scoreboard, indexed by tag
  logic [31:0] exp_tbl [16];
  int          test_tbl [16];
  int          unit_tbl [16];
  int          issue_cnt [16];
  int          ret_cnt [16];
  int          sent_cnt [num_tests];
  int          recv_cnt [num_tests];
  int          drv_err [num_tests];
  int          mon_err [num_tests];
  int          stray_err;
  int          wait_cnt [2];
  logic        prev_stall;
  logic [3:0]  prev_tag;
  logic [31:0] prev_data;
  logic [31:0] lfsr_q;
  logic [31:0] bp_level;  // ready when 4 random bits reach this
  logic [3:0]  next_tag;

  `include "fpu_cvt_model.svh"

  fpu_cvt_top uut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_op_i    (req_op),
    .req_rm_i    (req_rm),
    .req_data_i  (req_data),
    .req_tag_i   (req_tag),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_data_o  (res_data),
    .res_tag_o   (res_tag)
  );

  always #10 clk = ~clk;

  function automatic string test_name(input int t);
    case (t)
      0: return "reset";
      1: return "f2i_random";
      2: return "f2i_special";
      3: return "i2f_random";
      4: return "backpressure";
      default: return "mixed";
    endcase
  endfunction

  function automatic int in_flight();
    int n;
    n = 0;
    for (int k = 0; k < 16; k++) begin
      if (issue_cnt[k] != ret_cnt[k]) begin
        n++;
      end
    end
    return n;
  endfunction

  // ==========================================================
  // request driver
  // ==========================================================
  task automatic send(input fpu_cvt_pkg::op_e op, input logic [2:0] rm,
                      input logic [31:0] a, input int test);
    logic acc;
    while (issue_cnt[next_tag] != ret_cnt[next_tag]) begin
      @(posedge clk);
      #1;
    end
    exp_tbl[next_tag]  = (op == fpu_cvt_pkg::OP_F2I) ? f2i_ref(a, rm) : i2f_ref(a, rm);
    test_tbl[next_tag] = test;
    unit_tbl[next_tag] = (op == fpu_cvt_pkg::OP_F2I) ? int'(fpu_cvt_pkg::unit_f2i)
                                                     : int'(fpu_cvt_pkg::unit_i2f);
    req_valid = 1'b1;
    req_op    = op;
    req_rm    = rm;
    req_data  = a;
    req_tag   = next_tag;
    acc       = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = req_ready;  // transfer at the coming edge
      @(posedge clk);
      #1;
    end
    issue_cnt[next_tag]++;
    sent_cnt[test]++;
    req_valid = 1'b0;
    next_tag  = next_tag + 4'd1;
  endtask

  task automatic send_random(input int test);
    logic [31:0] pick;
    logic [31:0] a;
    logic [2:0]  rm;
    pick = take_bits(lfsr_q, 2);
    a    = take_bits(lfsr_q, 32);
    rm   = 3'(take_bits(lfsr_q, 3));
    if (pick[1]) begin
      a[30:23] = 8'd125 + {3'b0, a[27:23]};  // inside the rounding window
    end
    send(pick[0] ? fpu_cvt_pkg::OP_I2F : fpu_cvt_pkg::OP_F2I, rm, a, test);
  endtask

  initial begin : ready_drive
    logic [31:0] rdy_q;
    rdy_q     = 32'hc96f_bffc;
    res_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      res_ready = (take_bits(rdy_q, 4) >= bp_level);
    end
  end

  // ==========================================================
  // result monitor
  // ==========================================================
  always @(negedge clk) begin : monitor
    logic [3:0] t;
    int         u;
    logic       pend;
    if (!arst_n) begin
      prev_stall = 1'b0;
    end else begin
      assert (!prev_stall || (res_valid && res_tag == prev_tag && res_data == prev_data))
      else begin
        $display("a stalled result changed or was withdrawn before it was taken");
        stray_err++;
      end
      if (res_valid) begin
        t = res_tag;
        assert (issue_cnt[t] != ret_cnt[t]) else begin
          $display("result with tag %0d arrived while no such request was in flight", t);
          stray_err++;
        end
        if (issue_cnt[t] != ret_cnt[t]) begin
          assert (res_data == exp_tbl[t]) else begin
            $display("Mismatch in %s: tag %0d expected %h actual %h",
                     test_name(test_tbl[t]), t, exp_tbl[t], res_data);
            mon_err[test_tbl[t]]++;
          end
          if (res_ready) begin
            ret_cnt[t]++;
            recv_cnt[test_tbl[t]]++;
            u           = unit_tbl[t];
            wait_cnt[u] = 0;
            pend        = 1'b0;
            for (int k = 0; k < 16; k++) begin
              if (issue_cnt[k] != ret_cnt[k] && unit_tbl[k] != u) begin
                pend = 1'b1;  // other unit holds a result
              end
            end
            if (pend) begin
              wait_cnt[1-u]++;
              assert (wait_cnt[1-u] <= 1) else begin
                $display("%s: unit %0d waited through %0d transfers of the other unit",
                         test_name(test_tbl[t]), 1 - u, wait_cnt[1-u]);
                mon_err[test_tbl[t]]++;
              end
            end
          end
        end
      end
      prev_stall = res_valid && !res_ready;
      prev_tag   = res_tag;
      prev_data  = res_data;
    end
  end

  // ==========================================================
  // stimulus and report
  // ==========================================================
  initial begin : stimulus
    logic [31:0] a;
    logic [2:0]  rm;
    logic [7:0]  e;
    int          fails;
    int          total;
    int          drain;
    lfsr_q    = 32'hc96f_bffc;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req_op    = fpu_cvt_pkg::OP_F2I;
    req_rm    = 3'd0;
    req_data  = 32'd0;
    req_tag   = 4'd0;
    bp_level  = 32'd0;
    next_tag  = 4'd0;
    total     = 0;
    drain     = 0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int k = 0; k < 2; k++) begin
      req_op = (k == 0) ? fpu_cvt_pkg::OP_F2I : fpu_cvt_pkg::OP_I2F;
      @(negedge clk);
      assert (res_valid == 1'b0) else begin
        $display("Mismatch in reset: res_valid_o expected 0 actual %b", res_valid);
        drv_err[0]++;
      end
      assert (req_ready == 1'b1) else begin
        $display("Mismatch in reset: req_ready_o expected 1 actual %b", req_ready);
        drv_err[0]++;
      end
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < n_f2i_rand; i++) begin
      a = take_bits(lfsr_q, 24);
      e = 8'd125 + 8'(take_bits(lfsr_q, 6) % 33);
      send(fpu_cvt_pkg::OP_F2I, 3'(i % 5), {a[23], e, a[22:0]}, 1);
    end
    for (int k = 0; k < 13; k++) begin
      for (int m = 0; m < 8; m++) begin
        send(fpu_cvt_pkg::OP_F2I, 3'(m), f2i_specials[k], 2);
      end
    end
    for (int k = 0; k < 8; k++) begin
      for (int m = 0; m < 5; m++) begin
        send(fpu_cvt_pkg::OP_I2F, 3'(m), i2f_fixed[k], 3);
      end
    end
    for (int i = 0; i < n_i2f - 40; i++) begin
      a  = take_bits(lfsr_q, 32);
      rm = 3'(take_bits(lfsr_q, 3));  // reserved codes too
      send(fpu_cvt_pkg::OP_I2F, rm, a, 3);
    end
    bp_level = 32'd8;  // about half the cycles stalled
    for (int i = 0; i < n_bp; i++) begin
      send_random(4);
    end
    bp_level = 32'd4;
    for (int i = 0; i < n_mixed; i++) begin
      send_random(5);
    end
    bp_level = 32'd0;
    while (in_flight() != 0 && drain < 200) begin
      @(posedge clk);
      #1;
      drain++;
    end
    repeat (4) @(posedge clk);
    for (int t = 0; t < num_tests; t++) begin
      assert (recv_cnt[t] == sent_cnt[t]) else begin
        $display("%s: %0d results never came back", test_name(t), sent_cnt[t] - recv_cnt[t]);
        drv_err[t]++;
      end
      fails = drv_err[t] + mon_err[t];
      total = total + fails;
      $display("%s: sent %0d received %0d errors %0d %s", test_name(t), sent_cnt[t],
               recv_cnt[t], fails, (fails == 0) ? "ok" : "FAILED");
    end
    total = total + stray_err;
    $display("%0d failed checks over %0d tests, %0d stray results", total, num_tests, stray_err);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(wd_cycles * 20);
    $display("watchdog expired after %0d cycles with %0d results outstanding",
             wd_cycles, in_flight());
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+verification
src/fpu_fmt_pkg.sv
src/fpu_cvt_pkg.sv
src/fpu_res_if.sv
src/fpu_classify.sv
src/fpu_round.sv
src/fpu_f2i.sv
src/fpu_i2f.sv
src/fpu_res_arbiter.sv
src/fpu_cvt_top.sv
verification/tb_fpu_cvt.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conversion subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_fpu_cvt -f tb.f

out=$(./obj_dir/Vtb_fpu_cvt 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED"
